//--- src/sms_loader_pkg.sv
// Cartridge loader shared definitions
// Host file indices, address constants, byte kinds, writer states
// and the records passed from the decode stage to the second stage
`default_nettype none

package sms_loader_pkg;

	// ========================================
	// Widths and host file indices
	// ========================================
	localparam int host_addr_w = 25;
	localparam int rom_addr_w = 22;

	localparam logic [7:0] idx_sysmode = 8'd4;   // Arcade system mode
	localparam logic [7:0] idx_dipsw = 8'd254;
	localparam logic [7:0] idx_cheat = 8'd255;
	localparam logic [4:0] idx_gg = 5'd2;        // Handheld cartridge

	// Copier header and cartridge ID location
	localparam int hdr_offset = 512;
	localparam logic [host_addr_w-1:0] id_base = 25'h7ffc;
	localparam logic [host_addr_w-1:0] id_check_addr = 25'h8000;
	localparam logic [31:0] ys_quirk_id = 32'h13_70_01_4f;  // Forces VDP version 1

	// ========================================
	// Types
	// ========================================
	typedef enum logic [1:0] {kind_rom, kind_cheat, kind_sysmode, kind_dipsw} load_kind_e;

	typedef enum logic {st_idle, st_wait_ack} writer_state_e;

	// One registered host byte
	typedef struct packed {
		logic valid;
		load_kind_e kind;
		logic [7:0] index;
		logic [host_addr_w-1:0] addr;
		logic [7:0] data;
		logic dl_start;   // Download level edges
		logic dl_end;
	} load_event_t;

	typedef struct packed {
		logic [7:0] sysmode;
		logic [2:0][7:0] dsw;
	} sys_config_t;

	typedef struct packed {
		logic [rom_addr_w-1:0] cart_mask;
		logic [rom_addr_w-1:0] cart_mask512;
		logic cart_sz512;   // Image carries a copier header
		logic gg;
		logic systeme;
		logic ys_quirk;
	} cart_profile_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

//--- src/load_decoder.sv
// Loader decode stage
// Registers each host byte with its kind and marks the edges of the
// download level. Keeps the arcade system-mode byte and DIP switches
`timescale 1ns/10ps
`default_nettype none

module load_decoder (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	input  wire                                   ioctl_download,
	input  wire                                   ioctl_wr,
	input  wire [7:0]                             ioctl_index,
	input  wire [sms_loader_pkg::host_addr_w-1:0] ioctl_addr,
	input  wire [7:0]                             ioctl_dout,
	output sms_loader_pkg::load_event_t           load_event,
	output sms_loader_pkg::sys_config_t           sys_config
);

	sms_loader_pkg::load_kind_e kind;
	logic dl_q;   // Previous download level

	always_comb begin
		case (ioctl_index)
			sms_loader_pkg::idx_cheat:   kind = sms_loader_pkg::kind_cheat;
			sms_loader_pkg::idx_dipsw:   kind = sms_loader_pkg::kind_dipsw;
			sms_loader_pkg::idx_sysmode: kind = sms_loader_pkg::kind_sysmode;
			default:                     kind = sms_loader_pkg::kind_rom;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		load_event.kind <= kind;
		load_event.index <= ioctl_index;
		if (ioctl_wr) begin   // Address holds the last byte written
			load_event.addr <= ioctl_addr;
			load_event.data <= ioctl_dout;
		end
		if (RESET) begin
			dl_q <= 1'b0;
			load_event.valid <= 1'b0;
			load_event.dl_start <= 1'b0;
			load_event.dl_end <= 1'b0;
		end else begin
			dl_q <= ioctl_download;
			load_event.valid <= ioctl_wr & ioctl_download;
			load_event.dl_start <= ioctl_download & ~dl_q;
			load_event.dl_end <= ~ioctl_download & dl_q;
		end
	end

	// System mode and DIP switch bytes
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sys_config <= '0;
		end else if (load_event.valid) begin
			if (load_event.kind == sms_loader_pkg::kind_sysmode && load_event.addr == '0)
				sys_config.sysmode <= load_event.data;
			if (load_event.kind == sms_loader_pkg::kind_dipsw &&
			    load_event.addr < sms_loader_pkg::host_addr_w'(3))
				sys_config.dsw[load_event.addr[1:0]] <= load_event.data;
		end
	end

	a_valid_in_download: assert property (@(posedge clk_sys) disable iff (RESET)
		load_event.valid |-> ioctl_download);

endmodule

`default_nettype wire

//--- src/rom_writer.sv
// ROM write path
// Hands each cartridge byte to memory through a toggle request and
// holds the host off with ioctl_wait until memory acknowledges
`timescale 1ns/10ps
`default_nettype none

module rom_writer (
	input  wire                                  clk_sys,
	input  wire                                  RESET,
	input  wire sms_loader_pkg::load_event_t     load_event,
	input  wire                                  rom_ack,
	output logic                                 rom_req,
	output logic [sms_loader_pkg::rom_addr_w-1:0] rom_waddr,
	output logic [7:0]                           rom_wdata,
	output logic                                 ioctl_wait
);

	sms_loader_pkg::writer_state_e state;
	logic rom_evt;
	logic rom_start;

	assign rom_evt = load_event.valid && load_event.kind == sms_loader_pkg::kind_rom;
	assign rom_start = load_event.dl_start && load_event.kind == sms_loader_pkg::kind_rom;
	assign ioctl_wait = (state == sms_loader_pkg::st_wait_ack);

	// ========================================
	// Request FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state <= sms_loader_pkg::st_idle;
			rom_req <= 1'b0;
			rom_waddr <= '0;
		end else begin
			case (state)
				sms_loader_pkg::st_idle: begin
					if (rom_evt) begin
						rom_req <= ~rom_req;   // Pending until ack follows
						state <= sms_loader_pkg::st_wait_ack;
					end
				end
				sms_loader_pkg::st_wait_ack: begin
					if (rom_ack == rom_req) begin
						rom_waddr <= rom_waddr + 1'b1;
						state <= sms_loader_pkg::st_idle;
					end
				end
				default: state <= sms_loader_pkg::st_idle;
			endcase
			if (rom_start)
				rom_waddr <= '0;   // New image starts at zero
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_evt)
			rom_wdata <= load_event.data;
	end

	// Host must wait for ioctl_wait before the next byte
	a_no_rom_while_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(state == sms_loader_pkg::st_wait_ack) |-> !rom_evt);

endmodule

`default_nettype wire

//--- src/cart_profile.sv
// Cartridge profile
// Tracks the size masks and copier header of the loaded image, the
// handheld and arcade flags and the title quirk from the cartridge ID.
// Maps CPU ROM read addresses through the active mask
`timescale 1ns/10ps
`default_nettype none

module cart_profile (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	input  wire sms_loader_pkg::load_event_t      load_event,
	input  wire [sms_loader_pkg::rom_addr_w-1:0]  rom_rd_addr,
	output sms_loader_pkg::cart_profile_t         profile,
	output logic [sms_loader_pkg::rom_addr_w-1:0] rom_raddr
);

	logic rom_evt;
	logic sysmode_evt;
	logic rom_start;
	logic rom_end;
	logic [sms_loader_pkg::rom_addr_w-1:0] byte_addr;
	logic [31:0] cart_id;

	assign rom_evt = load_event.valid && load_event.kind == sms_loader_pkg::kind_rom;
	assign sysmode_evt = load_event.valid && load_event.kind == sms_loader_pkg::kind_sysmode;
	assign rom_start = load_event.dl_start && load_event.kind == sms_loader_pkg::kind_rom;
	assign rom_end = load_event.dl_end && load_event.kind == sms_loader_pkg::kind_rom;
	assign byte_addr = load_event.addr[sms_loader_pkg::rom_addr_w-1:0];

	// ========================================
	// Profile registers
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			profile <= '0;
		end else begin
			if (rom_evt) begin
				profile.cart_mask <= (load_event.addr == '0) ? '0 :
					profile.cart_mask | byte_addr;
				profile.cart_mask512 <=
					(load_event.addr == sms_loader_pkg::host_addr_w'(sms_loader_pkg::hdr_offset)) ?
					'0 : profile.cart_mask512 |
					(byte_addr - sms_loader_pkg::rom_addr_w'(sms_loader_pkg::hdr_offset));
				profile.gg <= load_event.index[4:0] == sms_loader_pkg::idx_gg;
				if (load_event.index[4:0] inside {5'd1, 5'd2})
					profile.systeme <= 1'b0;   // Console cartridge
				if (load_event.addr == sms_loader_pkg::id_check_addr &&
				    cart_id == sms_loader_pkg::ys_quirk_id)
					profile.ys_quirk <= 1'b1;
			end
			if (sysmode_evt)
				profile.systeme <= 1'b1;
			if (rom_end)
				profile.cart_sz512 <= load_event.addr[9];   // Odd 512-byte block
			if (rom_start)
				profile.ys_quirk <= 1'b0;
		end
	end

	// Cartridge ID bytes, first byte most significant
	always_ff @(posedge clk_sys) begin
		if (rom_evt && load_event.addr[sms_loader_pkg::host_addr_w-1:2] ==
		    sms_loader_pkg::id_base[sms_loader_pkg::host_addr_w-1:2])
			cart_id[{~load_event.addr[1:0], 3'b000} +: 8] <= load_event.data;
	end

	// Read mapping skips the copier header when present
	always_comb begin
		if (profile.cart_sz512)
			rom_raddr = (rom_rd_addr + sms_loader_pkg::rom_addr_w'(sms_loader_pkg::hdr_offset)) &
				profile.cart_mask512;
		else
			rom_raddr = rom_rd_addr & profile.cart_mask;
	end

endmodule

`default_nettype wire

//--- src/cheat_assembler.sv
// Cheat record assembly
// Collects the 16 bytes of a cheat record into one code word and
// pulses code_valid once the last byte is in
`timescale 1ns/10ps
`default_nettype none

module cheat_assembler (
	input  wire                              clk_sys,
	input  wire                              RESET,
	input  wire sms_loader_pkg::load_event_t load_event,
	output sms_loader_pkg::cheat_code_t      code,
	output logic                             code_valid
);

	logic cheat_evt;
	logic [4:0] byte_lsb;   // Bit offset inside a 32-bit field

	assign cheat_evt = load_event.valid && load_event.kind == sms_loader_pkg::kind_cheat;
	assign byte_lsb = {load_event.addr[1:0], 3'b000};

	// Fields are little endian in the record
	always_ff @(posedge clk_sys) begin
		if (cheat_evt) begin
			case (load_event.addr[3:2])
				2'd0: code.flags[byte_lsb +: 8] <= load_event.data;
				2'd1: code.address[byte_lsb +: 8] <= load_event.data;
				2'd2: code.compare[byte_lsb +: 8] <= load_event.data;
				default: code.replace[byte_lsb +: 8] <= load_event.data;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_evt && load_event.addr[3:0] == 4'hf;   // Record complete
	end

	// Host paces bytes so a record never completes on back-to-back cycles
	a_single_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid);

endmodule

`default_nettype wire

//--- src/sms_loader_top.sv
// Cartridge loader top level
// Decode stage feeding the ROM writer, the cartridge profile and
// the cheat assembler
`timescale 1ns/10ps
`default_nettype none

module sms_loader_top (
	input  wire                                   clk_sys,
	input  wire                                   RESET,
	// Host download port
	input  wire                                   ioctl_download,
	input  wire                                   ioctl_wr,
	input  wire [7:0]                             ioctl_index,
	input  wire [sms_loader_pkg::host_addr_w-1:0] ioctl_addr,
	input  wire [7:0]                             ioctl_dout,
	output wire                                   ioctl_wait,
	// ROM memory
	output wire                                   rom_req,
	output wire [sms_loader_pkg::rom_addr_w-1:0]  rom_waddr,
	output wire [7:0]                             rom_wdata,
	input  wire                                   rom_ack,
	input  wire [sms_loader_pkg::rom_addr_w-1:0]  rom_rd_addr,
	output wire [sms_loader_pkg::rom_addr_w-1:0]  rom_raddr,
	// Loaded configuration
	output wire sms_loader_pkg::cart_profile_t    profile,
	output wire sms_loader_pkg::sys_config_t      sys_config,
	output wire sms_loader_pkg::cheat_code_t      code,
	output wire                                   code_valid
);

	wire sms_loader_pkg::load_event_t load_event;

	load_decoder load_decoder_i (.clk_sys, .RESET, .ioctl_download, .ioctl_wr, .ioctl_index,
		.ioctl_addr, .ioctl_dout, .load_event, .sys_config);

	rom_writer rom_writer_i (.clk_sys, .RESET, .load_event, .rom_ack, .rom_req, .rom_waddr,
		.rom_wdata, .ioctl_wait);

	cart_profile cart_profile_i (.clk_sys, .RESET, .load_event, .rom_rd_addr, .profile,
		.rom_raddr);

	cheat_assembler cheat_assembler_i (.clk_sys, .RESET, .load_event, .code, .code_valid);

endmodule

`default_nettype wire

//--- verification/tb_sms_loader_tasks.svh
// Loader testbench tasks
// Host download helpers and the directed tests
`ifndef TB_SMS_LOADER_TASKS_SVH
`define TB_SMS_LOADER_TASKS_SVH

function automatic logic [7:0] rom_byte(int addr);
	return 8'((addr * 29) ^ (addr >> 8) ^ 'h5a);
endfunction

// OR of all addresses from 0 to last
function automatic logic [sms_loader_pkg::rom_addr_w-1:0] or_range(int last);
	logic [sms_loader_pkg::rom_addr_w-1:0] acc;
	acc = '0;
	for (int a = 0; a <= last; a++)
		acc = acc | sms_loader_pkg::rom_addr_w'(a);
	return acc;
endfunction

task automatic report_error(string msg);
	$display("** Error at %0t: %s", $time, msg);
	errors++;
endtask

task automatic finish_test(string name, int start_errors);
	tests_run++;
	$display("%s: %s", name, (errors == start_errors) ? "passed" : "failed");
endtask

// One byte, then two cycles, then wait for ioctl_wait low
task automatic host_write(int addr, logic [7:0] data);
	int waited;
	waited = 0;
	if (timed_out)
		return;
	ioctl_addr <= sms_loader_pkg::host_addr_w'(addr);
	ioctl_dout <= data;
	ioctl_wr <= 1'b1;
	@(posedge clk_sys);
	ioctl_wr <= 1'b0;
	repeat (2) @(posedge clk_sys);
	while (ioctl_wait && waited < 64) begin
		@(posedge clk_sys);
		waited++;
	end
	if (ioctl_wait) begin
		$display("Timeout: ioctl_wait stayed high after the write to address %0h", addr);
		errors++;
		timed_out = 1'b1;
	end
endtask

task automatic download_begin(logic [7:0] index);
	ioctl_index <= index;
	@(posedge clk_sys);
	ioctl_download <= 1'b1;
	repeat (2) @(posedge clk_sys);
endtask

task automatic download_end();
	ioctl_download <= 1'b0;
	repeat (4) @(posedge clk_sys);   // dl_end reaches the profile
endtask

task automatic load_image(logic [7:0] index, int size);
	download_begin(index);
	for (int a = 0; a < size; a++)
		host_write(a, rom_byte(a));
	download_end();
endtask

task automatic check_mapping(logic header, logic [21:0] mask, logic [21:0] mask512);
	logic [sms_loader_pkg::rom_addr_w-1:0] rd;
	logic [sms_loader_pkg::rom_addr_w-1:0] expected;
	for (int i = 0; i < 6; i++) begin
		rd = sms_loader_pkg::rom_addr_w'(i * 'h0b6d93 + 'h1f0);
		expected = header ? (rd + 22'(sms_loader_pkg::hdr_offset)) & mask512 : rd & mask;
		rom_rd_addr <= rd;
		@(posedge clk_sys);
		if (rom_raddr != expected)
			report_error($sformatf("rom_raddr %h for %h, expected %h", rom_raddr, rd, expected));
	end
endtask

// ========================================
// Directed tests
// ========================================
task automatic test_rom_download();
	int start_errors;
	start_errors = errors;
	load_image(8'd1, 40);
	for (int a = 0; a < 40; a++)
		if (rom_mem[a] !== rom_byte(a))
			report_error($sformatf("ROM byte %0d is %h, expected %h", a, rom_mem[a], rom_byte(a)));
	if (rom_waddr != 40)
		report_error($sformatf("rom_waddr is %0d after 40 bytes", rom_waddr));
	if (ioctl_wait)
		report_error("ioctl_wait high after the download");
	finish_test("rom download", start_errors);
endtask

task automatic test_cart_masks();
	int start_errors;
	start_errors = errors;
	load_image(8'd2, 600);
	if (profile.cart_mask != or_range(599))
		report_error($sformatf("cart_mask %h, expected %h", profile.cart_mask, or_range(599)));
	if (profile.cart_mask512 != or_range(599 - sms_loader_pkg::hdr_offset))
		report_error($sformatf("cart_mask512 %h is wrong", profile.cart_mask512));
	if (profile.cart_sz512 != 1'((599 >> 9) & 1))
		report_error("cart_sz512 does not match bit 9 of the last address");
	if (!profile.gg)
		report_error("gg clear after an index 2 download");
	finish_test("cart masks", start_errors);
endtask

// Starts from the index 2 image, then a plain index 1 image
task automatic test_read_mapping();
	int start_errors;
	start_errors = errors;
	check_mapping(1'b1, or_range(599), or_range(599 - sms_loader_pkg::hdr_offset));
	load_image(8'd1, 100);
	if (profile.gg)
		report_error("gg still set after an index 1 download");
	check_mapping(1'b0, or_range(99), '0);
	finish_test("read mapping", start_errors);
endtask

task automatic test_quirk_detect();
	int start_errors;
	logic [31:0] id;
	start_errors = errors;
	for (int pass = 0; pass < 2; pass++) begin
		id = (pass == 0) ? sms_loader_pkg::ys_quirk_id : sms_loader_pkg::ys_quirk_id ^ 32'h100;
		download_begin(8'd1);
		host_write(0, 8'h00);
		for (int k = 0; k < 4; k++)
			host_write(sms_loader_pkg::id_base + k, id[31 - 8 * k -: 8]);   // MSB first
		host_write(sms_loader_pkg::id_check_addr, 8'hc3);
		download_end();
		if (profile.ys_quirk != (pass == 0))
			report_error($sformatf("ys_quirk is %b for ID %h", profile.ys_quirk, id));
	end
	finish_test("quirk detect", start_errors);
endtask

task automatic test_cheat_record();
	int start_errors;
	int start_pulses;
	int waited;
	logic [127:0] rec;   // Record bytes, byte 0 lowest
	start_errors = errors;
	start_pulses = code_pulses;
	waited = 0;
	download_begin(sms_loader_pkg::idx_cheat);
	for (int b = 0; b < 16; b++) begin
		rec[b * 8 +: 8] = 8'(b * 23 + 1) ^ 8'h96;
		host_write(b, rec[b * 8 +: 8]);
	end
	while (code_pulses == start_pulses && waited < 16) begin
		@(posedge clk_sys);
		waited++;
	end
	if (code_pulses == start_pulses) begin
		$display("Timeout: no code_valid pulse after the last cheat byte");
		errors++;
	end
	repeat (3) @(posedge clk_sys);
	download_end();
	if (code_pulses - start_pulses > 1)
		report_error("more than one code_valid pulse for one record");
	if (code != {rec[31:0], rec[63:32], rec[95:64], rec[127:96]})
		report_error($sformatf("cheat code %h, record %h", code, rec));
	finish_test("cheat record", start_errors);
endtask

task automatic test_sys_config();
	int start_errors;
	start_errors = errors;
	download_begin(sms_loader_pkg::idx_sysmode);
	host_write(0, 8'h3c);
	download_end();
	download_begin(sms_loader_pkg::idx_dipsw);
	host_write(0, 8'h81);
	host_write(1, 8'h42);
	host_write(2, 8'he7);
	download_end();
	if (sys_config != {8'h3c, 8'he7, 8'h42, 8'h81})
		report_error($sformatf("sys_config %h, expected 3ce74281", sys_config));
	if (!profile.systeme)
		report_error("systeme clear after a system-mode byte");
	load_image(8'd1, 8);
	if (profile.systeme)
		report_error("systeme still set after an index 1 download");
	finish_test("system config", start_errors);
endtask

`endif

//--- verification/tb_sms_loader.sv
// Cartridge loader testbench
// Streams host downloads into the loader, answers ROM writes with a
// memory model of random latency and runs the directed tests
`timescale 1ns/10ps
`default_nettype none

module tb_sms_loader;

	logic clk_sys;
	logic RESET;
	logic ioctl_download, ioctl_wr, ioctl_wait;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [sms_loader_pkg::host_addr_w-1:0] ioctl_addr;
	logic rom_req;
	logic rom_ack = 1'b0;
	logic [7:0] rom_wdata;
	logic [sms_loader_pkg::rom_addr_w-1:0] rom_waddr, rom_rd_addr, rom_raddr;
	sms_loader_pkg::cart_profile_t profile;
	sms_loader_pkg::sys_config_t sys_config;
	sms_loader_pkg::cheat_code_t code;
	logic code_valid;

	logic [7:0] rom_mem [0:1023];   // Low window of ROM
	logic mem_busy = 1'b0;
	logic [2:0] ack_delay = '0;
	integer seed = 56004;
	int code_pulses = 0;
	int errors = 0;
	int tests_run = 0;
	bit timed_out = 1'b0;

	sms_loader_top dut_i (.*);

	`include "tb_sms_loader_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================
	// ROM memory model
	// ========================================
	always @(posedge clk_sys) begin
		if (rom_req != rom_ack && !RESET) begin
			if (!mem_busy) begin
				mem_busy <= 1'b1;
				ack_delay <= 3'($unsigned($random(seed)) % 6);   // 1 to 6 cycles
			end else if (ack_delay == 0) begin
				rom_mem[rom_waddr[9:0]] <= rom_wdata;
				rom_ack <= rom_req;
				mem_busy <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 1'b1;
			end
		end
	end

	always @(posedge clk_sys) begin
		if (code_valid)
			code_pulses <= code_pulses + 1;   // Completed cheat records
	end

	initial begin
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		rom_rd_addr = '0;
		repeat (3) @(posedge clk_sys);
		RESET <= 1'b0;
		@(posedge clk_sys);
		test_rom_download();
		test_cart_masks();
		test_read_mapping();
		test_quirk_detect();
		test_cheat_record();
		test_sys_config();
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
src/sms_loader_pkg.sv
src/load_decoder.sv
src/rom_writer.sv
src/cart_profile.sv
src/cheat_assembler.sv
src/sms_loader_top.sv
verification/tb_sms_loader.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the cartridge loader testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sms_loader \
	-f project.f -Mdir obj_dir -o sim_tb_sms_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_sms_loader > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
exit 0
